/* all.f */
design/ball_link_pkg.sv
design/ball_frame_sequencer.sv
design/i2c_byte_master.sv
design/ball_link_top.sv
sim/ball_link_sva.sv
sim/ball_link_tb.sv

/* sim/ball_link_tb.sv */
`default_nettype none

module ball_link_tb;
    import ball_link_pkg::*;

    localparam logic [6:0] ADDR = 7'h55;
    // six frames of START, six nine-bit slots and STOP, four clocks per quarter
    localparam int LIMIT = 6 * (4 + 6 * 36 + 4) * 4 + 200;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        send = 1'b0;
    logic [9:0]  ball_y = '0;
    logic [7:0]  ball_vy = '0;
    logic [1:0]  gravity = '0;
    logic        collision = 1'b0;
    logic        abort = 1'b0;
    logic        scl;
    logic        sda_pull;
    logic        busy;
    logic        nack;
    logic        slave_pull = 1'b0;
    logic        ack_drive = 1'b0;
    logic        refuse_addr = 1'b0;
    logic        scl_prev = 1'b1;
    logic        sda_prev = 1'b1;
    logic [7:0]  shift_reg = '0;
    logic [7:0]  rx_q[$];
    logic [47:0] exp_bytes = '0;
    int          bit_cnt = 0;
    int          stop_cnt = 0;
    int          nack_cnt = 0;
    int          cycles = 0;
    int          errors = 0;
    int          mark = 0;
    int          passed = 0;
    int          failed = 0;
    string       test_name = "";
    wire         sda = !(sda_pull || slave_pull);

    always #20 clk = !clk;

    ball_link_top dut (.*, .sda_in(sda));

    // slave model, bus sampled mid cycle
    always @(negedge clk) begin
        if (scl && scl_prev && sda_prev && !sda) begin
            bit_cnt = 0;
        end else if (scl && scl_prev && !sda_prev && sda) begin
            stop_cnt++;
        end else if (scl && !scl_prev) begin
            if (bit_cnt < 8) begin
                shift_reg = {shift_reg[6:0], sda};
            end
            bit_cnt++;
            if (bit_cnt == 8) begin
                rx_q.push_back(shift_reg);
            end
        end else if (!scl && scl_prev && bit_cnt == 8) begin
            // ack slot, address refused on request
            ack_drive = !(refuse_addr && rx_q.size() == 1);
        end else if (!scl && scl_prev && bit_cnt == 9) begin
            ack_drive = 1'b0;
            bit_cnt = 0;
        end
        scl_prev = scl;
        sda_prev = sda;
        if (nack) begin
            nack_cnt++;
        end
        cycles++;
    end

    always @(posedge clk) begin
        slave_pull <= #5 ack_drive;
    end

    bus_released: assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> scl && sda)
        else begin
            $display("bus still held when busy fell in test %s", test_name);
            errors++;
        end

    initial begin
        wait (cycles >= LIMIT);
        $display("run stopped at the cycle limit of %0d, a frame never finished", LIMIT);
        $display("Done: errors found");
        $finish;
    end

    function automatic int error_total();
        return errors + dut.u_seq.u_sva.fail_count + dut.u_master.u_sva.fail_count;
    endfunction

    task automatic check(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("** Error: %s %s: expected %0h, actual %0h", test_name, what, expected,
                     actual);
            errors++;
        end
    endtask

    task automatic open_test(input string name);
        test_name = name;
        mark = error_total();
    endtask

    task automatic close_test();
        if (error_total() == mark) begin
            passed++;
            $display("test %s: pass", test_name);
        end else begin
            failed++;
            $display("test %s: fail, %0d errors", test_name, error_total() - mark);
        end
    endtask

    task automatic start_frame();
        ball_y    = 10'($urandom);
        ball_vy   = 8'($urandom);
        gravity   = 2'($urandom);
        collision = 1'($urandom);
        exp_bytes = {ADDR, 1'b0, ball_y[9:8], 6'b000000, ball_y[7:0], ball_vy,
                     6'b000000, gravity, 7'b0000000, collision};
        rx_q.delete();
        stop_cnt = 0;
        nack_cnt = 0;
        @(posedge clk);
        #5 send = 1'b1;
        @(posedge clk);
        #5 send = 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
            #5;
        end while (busy);
    endtask

    task automatic check_frame(input int count);
        check("byte count", count, rx_q.size());
        for (int i = 0; i < rx_q.size() && i < 1 + FRAME_BYTES; i++) begin
            check($sformatf("byte %0d", i), exp_bytes[47 - 8 * i -: 8], rx_q[i]);
        end
        check("stop count", 1, stop_cnt);
    endtask

    initial begin
        int abort_at;
        void'($urandom(32'h3001e98f));
        repeat (4) @(posedge clk);
        #5 reset = 1'b0;
        open_test("reset_state");
        check("scl sda_pull busy nack", 4'b1000, {scl, sda_pull, busy, nack});
        close_test();

        open_test("full_frame");
        start_frame();
        repeat (300) @(posedge clk);
        // second pulse lands mid frame
        #5 send = 1'b1;
        @(posedge clk);
        #5 send = 1'b0;
        wait_idle();
        check("nack pulses", 0, nack_cnt);
        check_frame(1 + FRAME_BYTES);
        close_test();
        open_test("send_while_busy");
        repeat (50) @(posedge clk);
        #5;
        check("busy", 0, busy);
        check_frame(1 + FRAME_BYTES);
        close_test();

        open_test("abort");
        abort_at = 2 + int'($urandom % 4);
        start_frame();
        do begin
            @(posedge clk);
            #5;
        end while (rx_q.size() < abort_at);
        abort = 1'b1;
        wait_idle();
        abort = 1'b0;
        check_frame(abort_at);
        close_test();

        open_test("nack");
        refuse_addr = 1'b1;
        start_frame();
        wait_idle();
        refuse_addr = 1'b0;
        check("nack pulses", 1, nack_cnt);
        check_frame(1);
        close_test();

        open_test("recovery");
        start_frame();
        wait_idle();
        check("nack pulses", 0, nack_cnt);
        check_frame(1 + FRAME_BYTES);
        close_test();

        $display("tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0 && error_total() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/ball_link_sva.sv */
`default_nettype none

module ball_link_sva #(
    parameter bit ON_MASTER = 1'b0
) (
    input logic       clk,
    input logic       reset,
    input logic [1:0] credit,
    input logic       cmd_valid,
    input logic       buf_free,
    input logic       framing,
    input logic       scl,
    input logic       sda_pull,
    input logic       idle
);

    int fail_count = 0;

    if (ON_MASTER) begin : g_master
        // a command only ever lands in an empty buffer
        credit_before_valid: assert property (@(posedge clk) disable iff (reset)
            cmd_valid |-> buf_free)
            else begin
                $error("cmd_valid issued with no credit left");
                fail_count++;
            end

        // data moves only while scl is low
        sda_stable: assert property (@(posedge clk) disable iff (reset)
            scl && $past(scl) && !framing |-> sda_pull == $past(sda_pull))
            else begin
                $error("sda changed while scl high outside start or stop");
                fail_count++;
            end
    end else begin : g_seq
        credit_range: assert property (@(posedge clk) disable iff (reset) credit <= 2'd1)
            else begin
                $error("credit counter outside 0 to 1");
                fail_count++;
            end
    end

    idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> idle)
        else begin
            $error("outputs not idle in the first cycle after reset");
            fail_count++;
        end

endmodule

bind ball_frame_sequencer ball_link_sva #(.ON_MASTER(1'b0)) u_sva (
    .clk(clk),
    .reset(reset),
    .credit(credit),
    .cmd_valid(cmd_valid),
    .buf_free(1'b1),
    .framing(1'b1),
    .scl(1'b1),
    .sda_pull(1'b0),
    .idle(!busy && !nack && !cmd_valid)
);

// bus timing and buffer occupancy on the master side
bind i2c_byte_master ball_link_sva #(.ON_MASTER(1'b1)) u_sva (
    .clk(clk),
    .reset(reset),
    .credit(2'd0),
    .cmd_valid(cmd_valid),
    .buf_free(!buf_full),
    .framing(phase != P_BITS),
    .scl(scl),
    .sda_pull(sda_pull),
    .idle(scl && !sda_pull && !credit_return && !ack_fail)
);

`default_nettype wire

/* design/ball_link_top.sv */
`default_nettype none

module ball_link_top #(
    parameter logic [6:0] SLAVE_ADDR     = 7'h55,
    parameter int         QUARTER_CYCLES = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       send,
    input  logic [9:0] ball_y,
    input  logic [7:0] ball_vy,
    input  logic [1:0] gravity,
    input  logic       collision,
    input  logic       abort,
    input  logic       sda_in,
    output logic       scl,
    output logic       sda_pull,
    output logic       busy,
    output logic       nack
);
    import ball_link_pkg::*;

    i2c_cmd_t cmd;
    logic     cmd_valid;
    logic     credit_return;
    logic     ack_fail;

    ball_frame_sequencer #(
        .SLAVE_ADDR(SLAVE_ADDR)
    ) u_seq (
        .clk(clk),
        .reset(reset),
        .send(send),
        .ball_y(ball_y),
        .ball_vy(ball_vy),
        .gravity(gravity),
        .collision(collision),
        .abort(abort),
        .credit_return(credit_return),
        .ack_fail(ack_fail),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .busy(busy),
        .nack(nack)
    );

    i2c_byte_master #(
        .QUARTER_CYCLES(QUARTER_CYCLES)
    ) u_master (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .sda_in(sda_in),
        .credit_return(credit_return),
        .ack_fail(ack_fail),
        .scl(scl),
        .sda_pull(sda_pull)
    );

endmodule

`default_nettype wire

/* design/i2c_byte_master.sv */
`default_nettype none

module i2c_byte_master #(
    parameter int QUARTER_CYCLES = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  ball_link_pkg::i2c_cmd_t cmd,
    input  logic                    cmd_valid,
    input  logic                    sda_in,
    output logic                    credit_return,
    output logic                    ack_fail,
    output logic                    scl,
    output logic                    sda_pull
);
    import ball_link_pkg::*;

    localparam int QW = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

    typedef enum logic [1:0] {
        P_START,
        P_BITS,
        P_STOP
    } phase_t;

    i2c_cmd_t    cmd_buf;
    logic        buf_full;
    logic        load;
    phase_t      phase;
    logic [1:0]  quarter;
    logic [3:0]  bit_idx;
    logic [QW-1:0] qcnt;
    logic        tick;
    logic        bus_open;
    logic        nack_bit;
    logic        tx_bit;

    assign load   = cmd_valid && !buf_full;
    assign tick   = buf_full && (qcnt == QW'(QUARTER_CYCLES - 1));
    assign tx_bit = cmd_buf.data[3'd7 - bit_idx[2:0]];

    always_ff @(posedge clk) begin
        if (load) begin
            cmd_buf <= cmd;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            buf_full      <= 1'b0;
            phase         <= P_STOP;
            quarter       <= 2'd0;
            bit_idx       <= 4'd0;
            qcnt          <= '0;
            bus_open      <= 1'b0;
            nack_bit      <= 1'b0;
            credit_return <= 1'b0;
            ack_fail      <= 1'b0;
        end else begin
            credit_return <= 1'b0;
            ack_fail      <= 1'b0;
            if (load) begin
                buf_full <= 1'b1;
                qcnt     <= '0;
                quarter  <= 2'd0;
                bit_idx  <= 4'd0;
                case (cmd.kind)
                    CMD_START_ADDR: begin
                        phase    <= P_START;
                        bus_open <= 1'b1;
                    end
                    CMD_DATA: begin
                        phase <= P_BITS;
                    end
                    default: begin
                        phase <= P_STOP;
                    end
                endcase
            end else if (buf_full) begin
                qcnt <= tick ? '0 : qcnt + QW'(1);
                if (tick) begin
                    quarter <= quarter + 2'd1;
                    // ack sampled mid high phase of the ninth clock
                    if (phase == P_BITS && bit_idx == 4'd8 && quarter == 2'd1) begin
                        nack_bit <= sda_in;
                    end
                    if (quarter == 2'd3) begin
                        case (phase)
                            P_START: begin
                                phase <= P_BITS;
                            end
                            P_BITS: begin
                                if (bit_idx == 4'd8) begin
                                    buf_full      <= 1'b0;
                                    credit_return <= 1'b1;
                                    ack_fail      <= nack_bit;
                                end else begin
                                    bit_idx <= bit_idx + 4'd1;
                                end
                            end
                            default: begin
                                buf_full      <= 1'b0;
                                credit_return <= 1'b1;
                                bus_open      <= 1'b0;
                            end
                        endcase
                    end
                end
            end
        end
    end

    // line levels per quarter, SCL parked low while the frame is open
    always_comb begin
        if (!buf_full) begin
            scl      = !bus_open;
            sda_pull = 1'b0;
        end else begin
            case (phase)
                P_START: begin
                    scl      = (quarter != 2'd3);
                    sda_pull = (quarter != 2'd0);
                end
                P_BITS: begin
                    scl      = (quarter == 2'd1) || (quarter == 2'd2);
                    sda_pull = (bit_idx != 4'd8) && !tx_bit;
                end
                default: begin
                    scl      = (quarter != 2'd0);
                    sda_pull = (quarter < 2'd2);
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/ball_frame_sequencer.sv */
`default_nettype none

module ball_frame_sequencer #(
    parameter logic [6:0] SLAVE_ADDR = 7'h55
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    send,
    input  logic [9:0]              ball_y,
    input  logic [7:0]              ball_vy,
    input  logic [1:0]              gravity,
    input  logic                    collision,
    input  logic                    abort,
    input  logic                    credit_return,
    input  logic                    ack_fail,
    output ball_link_pkg::i2c_cmd_t cmd,
    output logic                    cmd_valid,
    output logic                    busy,
    output logic                    nack
);
    import ball_link_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_STOP,
        S_FINISH
    } seq_state_t;

    seq_state_t  state, state_next;
    frame_word_u frame;
    byte_idx_t   byte_idx, byte_idx_next;
    logic [1:0]  credit;
    logic        stop_pending;
    logic        capture;
    logic        have_credit;

    assign capture     = (state == S_IDLE) && send;
    assign busy        = (state != S_IDLE);
    assign have_credit = (credit == 2'd1);

    // snapshot, all fields taken in the same cycle
    always_ff @(posedge clk) begin
        if (capture) begin
            frame.snap.pos_hi    <= {ball_y[9:8], 6'b000000};
            frame.snap.pos_lo    <= ball_y[7:0];
            frame.snap.vel_y     <= ball_vy;
            frame.snap.gravity   <= {6'b000000, gravity};
            frame.snap.collision <= {7'b0000000, collision};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= S_IDLE;
            byte_idx     <= '0;
            credit       <= 2'd1;
            stop_pending <= 1'b0;
            nack         <= 1'b0;
        end else begin
            state    <= state_next;
            byte_idx <= byte_idx_next;
            credit   <= credit - {1'b0, cmd_valid} + {1'b0, credit_return};
            nack     <= ack_fail;
            if (capture) begin
                stop_pending <= 1'b0;
            end else if (ack_fail) begin
                stop_pending <= 1'b1;
            end
        end
    end

    always_comb begin
        state_next    = state;
        byte_idx_next = byte_idx;
        cmd_valid     = 1'b0;
        cmd.kind      = CMD_STOP;
        cmd.data      = 8'h00;
        case (state)
            S_IDLE: begin
                if (send) begin
                    state_next    = S_ADDR;
                    byte_idx_next = '0;
                end
            end
            S_ADDR: begin
                cmd.kind = CMD_START_ADDR;
                cmd.data = {SLAVE_ADDR, 1'b0};
                if (have_credit) begin
                    cmd_valid  = 1'b1;
                    state_next = S_DATA;
                end
            end
            S_DATA: begin
                // abort or refused byte cuts straight to STOP
                if (abort || stop_pending) begin
                    if (have_credit) begin
                        cmd_valid  = 1'b1;
                        state_next = S_FINISH;
                    end
                end else begin
                    cmd.kind = CMD_DATA;
                    cmd.data = frame.bytes[byte_idx];
                    if (have_credit) begin
                        cmd_valid     = 1'b1;
                        byte_idx_next = byte_idx + byte_idx_t'(1);
                        if (byte_idx == byte_idx_t'(FRAME_BYTES - 1)) begin
                            state_next = S_STOP;
                        end
                    end
                end
            end
            S_STOP: begin
                if (have_credit) begin
                    cmd_valid  = 1'b1;
                    state_next = S_FINISH;
                end
            end
            S_FINISH: begin
                // wait for the bus to be released
                if (credit_return) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/ball_link_pkg.sv */
`default_nettype none

package ball_link_pkg;

    // bytes per snapshot on the wire, after the address
    localparam int FRAME_BYTES = 5;

    typedef logic [$clog2(FRAME_BYTES)-1:0] byte_idx_t;

    // wire order is top field first
    typedef struct packed {
        logic [7:0] pos_hi;
        logic [7:0] pos_lo;
        logic [7:0] vel_y;
        logic [7:0] gravity;
        logic [7:0] collision;
    } ball_snapshot_t;

    // written through snap, sent through bytes
    typedef union packed {
        ball_snapshot_t                  snap;
        logic [0:FRAME_BYTES-1][7:0]     bytes;
    } frame_word_u;

    typedef enum logic [1:0] {
        CMD_START_ADDR,
        CMD_DATA,
        CMD_STOP
    } i2c_cmd_kind_e;

    // for CMD_START_ADDR data is {addr, 1'b0}
    typedef struct packed {
        i2c_cmd_kind_e kind;
        logic [7:0]    data;
    } i2c_cmd_t;

endpackage

`default_nettype wire
